/* hdl/snn_pkg.sv */
/* Shared widths and types for the spiking neuron block.
   Imported by every RTL file that touches weights, sums or configuration. */

package snn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////
	localparam int WEIGHT_BITS    = 8;
	localparam int MAX_ROWS       = 16;  // Weight memory depth
	localparam int ROW_BITS       = 4;
	localparam int ROW_CNT_BITS   = 5;   // Holds 0 to 16 rows used
	localparam int SUM_BITS       = 12;  // 16 rows of 8-bit weights
	localparam int GROUP_SUM_BITS = 15;  // Up to 8 neuron sums

	typedef logic signed [WEIGHT_BITS-1:0]    weight_t;
	typedef logic signed [SUM_BITS-1:0]       neuron_sum_t;
	typedef logic signed [GROUP_SUM_BITS-1:0] group_sum_t;

	// 12-bit configuration word from the controller
	typedef struct packed {
		logic                    valid;
		logic [3:0]              block_id;
		logic [1:0]              group_log2;  // Group size is 1 << group_log2
		logic [ROW_CNT_BITS-1:0] rows_used;
	} block_info_t;

endpackage

/* hdl/weight_wr_if.sv */
/* Weight write path from the byte loader into the row memory.
   One lane write per cycle while we is high; there is no back-pressure. */

`timescale 1ns/1ps

interface weight_wr_if import snn_pkg::*; #(
	parameter int NUM_NEURONS = 8
);

	logic                           we;
	logic [ROW_BITS-1:0]            row;
	logic [$clog2(NUM_NEURONS)-1:0] lane;   // Neuron position in the row
	weight_t                        data;

	modport loader (output we, output row, output lane, output data);
	modport memory (input we, input row, input lane, input data);

endinterface

/* hdl/weight_loader.sv */
/* Turns the byte stream of weights into row and lane writes.
   Rows arrive in order with neuron 0 first; done holds until reset. */

`timescale 1ns/1ps

module weight_loader import snn_pkg::*; #(
	parameter int NUM_NEURONS = 8
) (
	input  logic             CLK,
	input  logic             RESET_N,
	input  logic             w_valid,
	input  weight_t          weight_in,
	output logic             w_request,
	output logic             w_set_done,
	weight_wr_if.loader      wr
);

	localparam int LANE_BITS = $clog2(NUM_NEURONS);
	localparam logic [LANE_BITS-1:0] LAST_LANE = LANE_BITS'(NUM_NEURONS - 1);
	localparam logic [ROW_BITS-1:0]  LAST_ROW  = ROW_BITS'(MAX_ROWS - 1);

	logic [LANE_BITS-1:0] lane_cnt;
	logic [ROW_BITS-1:0]  row_cnt;
	logic                 accept;

	assign accept    = w_valid && !w_set_done;  // Late bytes dropped
	assign w_request = !w_set_done;

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			lane_cnt   <= '0;
			row_cnt    <= '0;
			w_set_done <= 1'b0;
			wr.we      <= 1'b0;
		end else begin
			wr.we <= accept;
			if (accept) begin
				if (lane_cnt == LAST_LANE) begin
					lane_cnt <= '0;
					if (row_cnt == LAST_ROW)
						w_set_done <= 1'b1;  // Whole memory written
					else
						row_cnt <= row_cnt + 1'b1;
				end else begin
					lane_cnt <= lane_cnt + 1'b1;
				end
			end
		end
	end

	// Write address and byte one cycle behind the accept
	always_ff @(posedge CLK) begin
		if (accept) begin
			wr.row  <= row_cnt;
			wr.lane <= lane_cnt;
			wr.data <= weight_in;
		end
	end

endmodule

/* hdl/weight_sram.sv */
/* Weight row memory with MAX_ROWS rows of one weight per neuron.
   Writes go to a single lane; a read returns the whole row a cycle later. */

`timescale 1ns/1ps

module weight_sram import snn_pkg::*; #(
	parameter int NUM_NEURONS = 8
) (
	input  logic                CLK,
	weight_wr_if.memory         wr,
	input  logic                rd_en,
	input  logic [ROW_BITS-1:0] rd_row,
	output weight_t             rd_weights [NUM_NEURONS]
);

	weight_t mem [MAX_ROWS][NUM_NEURONS];

	always_ff @(posedge CLK) begin
		if (wr.we)
			mem[wr.row][wr.lane] <= wr.data;  // Single lane write
	end

	always_ff @(posedge CLK) begin
		if (rd_en)
			rd_weights <= mem[rd_row];  // Registered row read
	end

endmodule

/* hdl/front_ctrl.sv */
/* Front phase control for block configuration, row sequencing and spike fan-out.
   en cycles read rows until rows_used is reached and then front_done holds. */

`timescale 1ns/1ps

module front_ctrl import snn_pkg::*; #(
	parameter int         NUM_NEURONS = 8,
	parameter logic [3:0] BLOCK_ID    = 4'd3
) (
	input  logic                   CLK,
	input  logic                   RESET_N,
	input  logic                   start,
	input  logic                   en,
	input  logic [7:0]             data_in,
	input  block_info_t            block_info,
	output logic                   rd_en,
	output logic [ROW_BITS-1:0]    rd_row,
	output logic                   clear,
	output logic                   acc_en,
	output logic [NUM_NEURONS-1:0] spikes,
	output logic [1:0]             group_log2,
	output logic                   front_done
);

	block_info_t             cfg;
	logic [ROW_CNT_BITS-1:0] row_cnt;   // Rows consumed since start
	logic [7:0]              data_q;
	logic [2:0]              lane_mask;

	////////////////////////////////////////////////////////////////////////////
	// Configuration
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N)
			cfg <= '0;
		else if (block_info.valid && block_info.block_id == BLOCK_ID)
			cfg <= block_info;  // Words for other blocks ignored
	end

	assign group_log2 = cfg.group_log2;

	////////////////////////////////////////////////////////////////////////////
	// Row sequencing
	////////////////////////////////////////////////////////////////////////////
	assign rd_en  = en && !start && (row_cnt < cfg.rows_used);
	assign rd_row = row_cnt[ROW_BITS-1:0];
	assign clear  = start;

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			row_cnt    <= '0;
			acc_en     <= 1'b0;
			front_done <= 1'b0;
		end else begin
			acc_en <= rd_en;  // Lines up with the memory output
			if (start) begin
				row_cnt    <= '0;
				front_done <= 1'b0;
			end else begin
				if (rd_en)
					row_cnt <= row_cnt + 1'b1;
				if (acc_en && row_cnt == cfg.rows_used)
					front_done <= 1'b1;  // Last row accumulated
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_en)
			data_q <= data_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// Spike fan-out
	////////////////////////////////////////////////////////////////////////////
	assign lane_mask = 3'((1 << cfg.group_log2) - 1);

	always_comb begin
		for (int n = 0; n < NUM_NEURONS; n++)
			spikes[n] = data_q[3'(n) & lane_mask];  // Bit n mod group size
	end

endmodule

/* hdl/neuron_array.sv */
/* One signed accumulator per neuron.
   Adds the row weight when the neuron's spike is set; clear zeroes all. */

`timescale 1ns/1ps

module neuron_array import snn_pkg::*; #(
	parameter int NUM_NEURONS = 8
) (
	input  logic                   CLK,
	input  logic                   RESET_N,
	input  logic                   clear,
	input  logic                   acc_en,
	input  logic [NUM_NEURONS-1:0] spikes,
	input  weight_t                weights [NUM_NEURONS],
	output neuron_sum_t            sums [NUM_NEURONS]
);

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			for (int n = 0; n < NUM_NEURONS; n++)
				sums[n] <= '0;
		end else if (clear) begin
			for (int n = 0; n < NUM_NEURONS; n++)
				sums[n] <= '0;  // New front phase
		end else if (acc_en) begin
			for (int n = 0; n < NUM_NEURONS; n++) begin
				if (spikes[n])
					sums[n] <= sums[n] + weights[n];  // Sign extended add
			end
		end
	end

endmodule

/* hdl/back_combiner.sv */
/* Back phase that captures neuron sums on request and sums them per group.
   Streams one spike per group that is set when the group sum is non-negative. */

`timescale 1ns/1ps

module back_combiner import snn_pkg::*; #(
	parameter int NUM_NEURONS = 8
) (
	input  logic        CLK,
	input  logic        RESET_N,
	input  logic        request,
	input  logic        front_done,
	input  logic [1:0]  group_log2,
	input  neuron_sum_t sums [NUM_NEURONS],
	output logic        out_spike_valid,
	output logic        out_spike,
	output logic        back_done
);

	localparam int IDX_BITS  = $clog2(NUM_NEURONS);
	localparam int MAX_GROUP = 8;  // Largest group size

	neuron_sum_t         cap_sums [NUM_NEURONS];
	logic [1:0]          cap_log2;
	logic [IDX_BITS-1:0] grp_idx;
	logic [IDX_BITS-1:0] grp_base;
	logic                busy;
	logic                last_grp;
	logic                accept;
	group_sum_t          group_sum;
	group_sum_t          group_sum_q;

	// Idle once the last output has left the pipe
	assign accept   = request && front_done && !busy && !out_spike_valid;
	assign grp_base = grp_idx << cap_log2;
	assign last_grp = (grp_idx == IDX_BITS'((NUM_NEURONS >> cap_log2) - 1));

	always_comb begin
		group_sum = '0;
		for (int k = 0; k < MAX_GROUP; k++) begin
			if (k < (1 << cap_log2))
				group_sum = group_sum + group_sum_t'(cap_sums[grp_base + IDX_BITS'(k)]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Group sequencing
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			busy            <= 1'b0;
			grp_idx         <= '0;
			cap_log2        <= '0;
			out_spike_valid <= 1'b0;
			back_done       <= 1'b0;
		end else begin
			out_spike_valid <= busy;  // Group sum registered this cycle
			if (accept) begin
				busy      <= 1'b1;
				grp_idx   <= '0;
				cap_log2  <= group_log2;
				back_done <= 1'b0;
			end else begin
				if (busy) begin
					if (last_grp)
						busy <= 1'b0;
					else
						grp_idx <= grp_idx + 1'b1;
				end
				if (out_spike_valid && !busy)
					back_done <= 1'b1;  // Last spike just went out
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			cap_sums <= sums;  // Frees the neurons for the next front phase
		if (busy)
			group_sum_q <= group_sum;
	end

	assign out_spike = out_spike_valid && !group_sum_q[GROUP_SUM_BITS-1];

endmodule

/* hdl/snn_block.sv */
/* Top level of one spiking neuron block.
   Weights are loaded once, then each start/en run feeds the neurons and
   a request streams one spike per neuron group. */

`timescale 1ns/1ps

module snn_block import snn_pkg::*; #(
	parameter int         NUM_NEURONS = 8,
	parameter logic [3:0] BLOCK_ID    = 4'd3
) (
	input  logic                   CLK,
	input  logic                   RESET_N,
	input  logic                   start,
	input  logic                   en,
	input  logic                   request,
	input  logic [7:0]             data_in,
	input  logic [11:0]            block_info,
	input  logic                   w_valid,
	input  logic [WEIGHT_BITS-1:0] weight_in,
	output logic                   w_request,
	output logic                   w_set_done,
	output logic                   front_done,
	output logic                   out_spike_valid,
	output logic                   out_spike,
	output logic                   back_done
);

	logic                   rd_en;
	logic [ROW_BITS-1:0]    rd_row;
	weight_t                rd_weights [NUM_NEURONS];
	logic                   clear;
	logic                   acc_en;
	logic [NUM_NEURONS-1:0] spikes;
	neuron_sum_t            sums [NUM_NEURONS];
	logic [1:0]             group_log2;

	weight_wr_if #(.NUM_NEURONS(NUM_NEURONS)) wr_if ();

	weight_loader #(.NUM_NEURONS(NUM_NEURONS)) loader_inst (
		.CLK        (CLK),
		.RESET_N    (RESET_N),
		.w_valid    (w_valid),
		.weight_in  (weight_in),
		.w_request  (w_request),
		.w_set_done (w_set_done),
		.wr         (wr_if.loader)
	);

	weight_sram #(.NUM_NEURONS(NUM_NEURONS)) sram_inst (
		.CLK        (CLK),
		.wr         (wr_if.memory),
		.rd_en      (rd_en),
		.rd_row     (rd_row),
		.rd_weights (rd_weights)
	);

	front_ctrl #(
		.NUM_NEURONS (NUM_NEURONS),
		.BLOCK_ID    (BLOCK_ID)
	) front_inst (
		.CLK        (CLK),
		.RESET_N    (RESET_N),
		.start      (start),
		.en         (en),
		.data_in    (data_in),
		.block_info (block_info_t'(block_info)),
		.rd_en      (rd_en),
		.rd_row     (rd_row),
		.clear      (clear),
		.acc_en     (acc_en),
		.spikes     (spikes),
		.group_log2 (group_log2),
		.front_done (front_done)
	);

	neuron_array #(.NUM_NEURONS(NUM_NEURONS)) neurons_inst (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.clear   (clear),
		.acc_en  (acc_en),
		.spikes  (spikes),
		.weights (rd_weights),
		.sums    (sums)
	);

	back_combiner #(.NUM_NEURONS(NUM_NEURONS)) back_inst (
		.CLK             (CLK),
		.RESET_N         (RESET_N),
		.request         (request),
		.front_done      (front_done),
		.group_log2      (group_log2),
		.sums            (sums),
		.out_spike_valid (out_spike_valid),
		.out_spike       (out_spike),
		.back_done       (back_done)
	);

endmodule

/* tb/clock_gen.sv */
/* Clock and reset source for the testbench.
   8 ns clock and a reset held low for the first 4 rising edges. */

`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK,
	output logic RESET_N
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		RESET_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RESET_N <= 1'b1;  // Released on a rising edge
	end

endmodule

/* tb/snn_block_tb.sv */
/* Testbench for the spiking neuron block.
   Loads xorshift weights, replays the tests listed in the input file and checks
   the front_done timing and every streamed spike against a software model. */

`timescale 1ns/1ps

module snn_block_tb;

	localparam int         NUM_NEURONS     = 8;
	localparam int         NUM_ROWS        = 16;
	localparam logic [3:0] BLOCK_ID        = 4'd3;
	localparam int         NUM_TESTS       = 7;
	localparam int         OVERLAP_TEST    = 5;   // Streams under the next front phase
	localparam int         EXTRA_EN        = 3;   // en cycles past rows_used
	localparam int         EXTRA_BYTES     = 4;   // Bytes offered after the load
	localparam int         STIM_WORDS      = 128;
	localparam int         BACK_LIMIT      = NUM_NEURONS + 8;
	localparam int         CLK_PERIOD      = 8;
	localparam logic [31:0] SEED           = 32'd97;
	localparam int         LOAD_CYCLES     = NUM_ROWS * NUM_NEURONS + 20;
	localparam int         WATCHDOG_CYCLES =
		NUM_TESTS * (NUM_ROWS + NUM_NEURONS + 20) + LOAD_CYCLES;

	logic        CLK;
	logic        RESET_N;
	logic        start;
	logic        en;
	logic        request;
	logic [7:0]  data_in;
	logic [11:0] block_info;
	logic        w_valid;
	logic [7:0]  weight_in;
	logic        w_request;
	logic        w_set_done;
	logic        front_done;
	logic        out_spike_valid;
	logic        out_spike;
	logic        back_done;

	logic signed [7:0] w_model [NUM_ROWS][NUM_NEURONS];  // Copy of the loaded weights
	logic [7:0]        stim_data [NUM_TESTS][NUM_ROWS];
	int                cfg_id [NUM_TESTS];
	int                cfg_log2 [NUM_TESTS];
	int                cfg_rows [NUM_TESTS];
	bit                exp_spike [NUM_TESTS][NUM_NEURONS];
	int                exp_count [NUM_TESTS];
	int                errs [NUM_TESTS + 1];  // Slot 0 is the weight load
	int                cur_log2;              // Configuration the DUT should hold
	int                cur_rows;
	logic [31:0]       rng_state;

	clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) clk_inst (
		.CLK     (CLK),
		.RESET_N (RESET_N)
	);

	snn_block #(.NUM_NEURONS(NUM_NEURONS), .BLOCK_ID(BLOCK_ID)) snn_block_inst (
		.CLK             (CLK),
		.RESET_N         (RESET_N),
		.start           (start),
		.en              (en),
		.request         (request),
		.data_in         (data_in),
		.block_info      (block_info),
		.w_valid         (w_valid),
		.weight_in       (weight_in),
		.w_request       (w_request),
		.w_set_done      (w_set_done),
		.front_done      (front_done),
		.out_spike_valid (out_spike_valid),
		.out_spike       (out_spike),
		.back_done       (back_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;

		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic log_error(input int slot, input string msg);
		errs[slot]++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic log_failure(input int slot, input string msg);
		errs[slot]++;
		$display("Failure in test %0d: %s", slot, msg);
	endtask

	task automatic report_test(input int slot, input string what);
		if (errs[slot] == 0)
			$display("test %0d (%s): ok", slot, what);
		else
			$display("test %0d (%s): FAILED with %0d errors", slot, what, errs[slot]);
	endtask

	task automatic read_stimulus(output bit ok);
		logic [7:0] mem [STIM_WORDS];
		int         pos;

		$readmemh("tb/snn_block_input.txt", mem);
		ok  = 1'b1;
		pos = 0;
		for (int t = 0; t < NUM_TESTS && ok; t++) begin
			if (pos + 2 >= STIM_WORDS || $isunknown(mem[pos + 2]) ||
			    mem[pos + 2] == 0 || mem[pos + 2] > NUM_ROWS || mem[pos + 1] > 3) begin
				ok = 1'b0;
			end else begin
				cfg_id[t]   = int'(mem[pos]);
				cfg_log2[t] = int'(mem[pos + 1]);
				cfg_rows[t] = int'(mem[pos + 2]);
				for (int j = 0; j < cfg_rows[t]; j++)
					stim_data[t][j] = mem[pos + 3 + j];
				pos = pos + 3 + cfg_rows[t];
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Weight load, front phase and back phase
	////////////////////////////////////////////////////////////////////////////
	task automatic load_weights();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int n = 0; n < NUM_NEURONS; n++) begin
				rng_state     = xorshift32(rng_state);
				w_model[r][n] = rng_state[7:0];
				@(posedge CLK);
				w_valid   <= 1'b1;
				weight_in <= rng_state[7:0];
				@(negedge CLK);
				assert (w_set_done === 1'b0 && w_request === 1'b1) else
					log_error(0, $sformatf("load done early at row %0d lane %0d", r, n));
			end
		end
		for (int k = 0; k < EXTRA_BYTES; k++) begin
			@(posedge CLK);
			weight_in <= 8'h7f;  // Would raise sums if it got in
			@(negedge CLK);
			assert (w_set_done === 1'b1 && w_request === 1'b0) else
				log_error(0, $sformatf("w_set_done %b w_request %b, %0d cycles after last byte",
					w_set_done, w_request, k + 1));
		end
		@(posedge CLK);
		w_valid <= 1'b0;
	endtask

	task automatic run_front(input int t);
		logic [7:0] drv [NUM_ROWS + EXTRA_EN];
		int         acc [NUM_NEURONS];
		int         n_en;
		int         gs;
		int         gsum;
		logic       exp_done;

		if (cfg_id[t] == int'(BLOCK_ID)) begin  // Foreign words leave the config alone
			cur_log2 = cfg_log2[t];
			cur_rows = cfg_rows[t];
		end
		n_en = cur_rows + EXTRA_EN;

		@(posedge CLK);
		block_info <= {1'b1, 4'(cfg_id[t]), 2'(cfg_log2[t]), 5'(cfg_rows[t])};
		@(posedge CLK);
		block_info <= '0;
		start      <= 1'b1;
		for (int j = 0; j < n_en; j++) begin
			if (j < cfg_rows[t]) begin
				drv[j] = stim_data[t][j];
			end else begin
				rng_state = xorshift32(rng_state);
				drv[j]    = rng_state[7:0];  // Filler beyond the listed bytes
			end
			@(posedge CLK);
			start   <= 1'b0;
			en      <= 1'b1;
			data_in <= drv[j];
			@(negedge CLK);
			exp_done = (cur_rows > 0) && (j >= cur_rows + 1);
			assert (front_done === exp_done) else
				log_error(t + 1, $sformatf("front_done %b after en cycle %0d, expected %b",
					front_done, j, exp_done));
		end
		@(posedge CLK);
		en      <= 1'b0;
		data_in <= '0;
		@(negedge CLK);
		assert (front_done === 1'b1) else
			log_error(t + 1, "front_done fell after en went low");

		// Expected group spikes from the first cur_rows rows
		gs = 1 << cur_log2;
		for (int n = 0; n < NUM_NEURONS; n++) begin
			acc[n] = 0;
			for (int r = 0; r < cur_rows; r++) begin
				if (drv[r][n % gs])
					acc[n] += int'(w_model[r][n]);
			end
		end
		exp_count[t] = NUM_NEURONS / gs;
		for (int k = 0; k < exp_count[t]; k++) begin
			gsum = 0;
			for (int i = 0; i < gs; i++)
				gsum += acc[k * gs + i];
			exp_spike[t][k] = (gsum >= 0);
		end
	endtask

	task automatic run_back(input int t);
		int cyc;
		int nvalid;
		bit done_seen;

		cyc       = 1;
		nvalid    = 0;
		done_seen = 1'b0;
		assert (front_done === 1'b1) else
			log_failure(t + 1, "front_done was low when the request was issued");
		@(posedge CLK);
		request <= 1'b1;
		@(posedge CLK);
		request <= 1'b0;
		while (!done_seen && cyc <= BACK_LIMIT) begin
			@(negedge CLK);  // Cycle cyc after the request cycle
			if (out_spike_valid === 1'b1) begin
				assert (cyc == nvalid + 2) else
					log_error(t + 1, $sformatf("output %0d valid %0d cycles after request",
						nvalid, cyc));
				if (nvalid < exp_count[t]) begin
					assert (out_spike === exp_spike[t][nvalid]) else
						log_error(t + 1, $sformatf("group %0d spike %b, expected %b",
							nvalid, out_spike, exp_spike[t][nvalid]));
				end
				nvalid++;
			end
			if (back_done === 1'b1)
				done_seen = 1'b1;
			else
				cyc++;
		end
		assert (done_seen) else
			log_failure(t + 1, "back_done did not rise after the request");
		if (done_seen) begin
			assert (nvalid == exp_count[t]) else
				log_error(t + 1, $sformatf("%0d valid outputs, expected %0d",
					nvalid, exp_count[t]));
			assert (cyc == exp_count[t] + 2) else
				log_error(t + 1, $sformatf("back_done rose %0d cycles after request", cyc));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		bit stim_ok;
		int total;
		int failed;

		start      <= 1'b0;
		en         <= 1'b0;
		request    <= 1'b0;
		data_in    <= '0;
		block_info <= '0;
		w_valid    <= 1'b0;
		weight_in  <= '0;
		rng_state  = SEED;
		cur_log2   = 0;
		cur_rows   = 0;
		for (int s = 0; s <= NUM_TESTS; s++)
			errs[s] = 0;

		read_stimulus(stim_ok);
		if (!stim_ok) begin
			$display("The stimulus file tb/snn_block_input.txt is missing or malformed");
			$display("Test failures found");
			$finish;
		end else begin
			wait (RESET_N === 1'b1);
			@(negedge CLK);
			assert (w_request === 1'b1 && w_set_done === 1'b0 && front_done === 1'b0 &&
			        out_spike_valid === 1'b0 && out_spike === 1'b0 && back_done === 1'b0) else
				log_error(0, "outputs not at their reset values");
			load_weights();
			report_test(0, "weight load");

			run_front(0);
			for (int t = 0; t < NUM_TESTS; t++) begin
				if (t == OVERLAP_TEST && t + 1 < NUM_TESTS) begin
					fork
						run_back(t);
						run_front(t + 1);  // New start while the spikes stream
					join
				end else begin
					run_back(t);
					if (t + 1 < NUM_TESTS)
						run_front(t + 1);
				end
				report_test(t + 1, $sformatf("block %0d, group %0d, %0d rows",
					cfg_id[t], 1 << cfg_log2[t], cfg_rows[t]));
			end

			total  = 0;
			failed = 0;
			for (int s = 0; s <= NUM_TESTS; s++) begin
				total += errs[s];
				if (errs[s] != 0)
					failed++;
			end
			$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, failed, total);
			if (total == 0)
				$display("All tests passed!");
			else
				$display("Test failures found");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the run took longer than the tests allow");
		$display("Test failures found");
		$finish;
	end

endmodule

/* tb/snn_block_input.txt */
// Columns: block id, group size code (log2), rows used, then one data_in byte per row
// All values hex, one test per line
3 0 10 a5 3c ff 01 80 7e 55 aa 0f f0 c3 96 69 12 ed 5a
3 1 0a 0f f0 33 cc 5a a5 81 7e 24 db
3 2 05 01 0e 0b 07 0f
3 3 0c ff 00 ff 00 aa 55 01 02 04 08 10 20
// Foreign block id, the previous group size and row count stay in force
5 0 03 c3 3c 99
// Back phase of this test overlaps the front phase of the next
3 0 07 ff 00 ff 81 42 24 18
3 2 0e 11 22 44 88 0f 1e 3c 78 f0 e1 c3 87 05 0a

/* flist.f */
hdl/snn_pkg.sv
hdl/weight_wr_if.sv
hdl/weight_loader.sv
hdl/weight_sram.sv
hdl/front_ctrl.sv
hdl/neuron_array.sv
hdl/back_combiner.sv
hdl/snn_block.sv
tb/clock_gen.sv
tb/snn_block_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module snn_block_tb -o snn_block_sim
./obj_dir/snn_block_sim > sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without reported failures"
